//--- Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_timer.sv
  - csr_regfile.sv
  - csr_trap_ctrl.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_unit_assertions.sv
      - csr_unit_tb.sv

//--- csr_pkg.sv
package csr_pkg;

    localparam int xlen       = 32;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int hw_irq_w   = 8;
    localparam int lie_w      = 13;

    // architectural csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h040;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    localparam logic [ecode_w-1:0] ecode_int = 6'h00;
    localparam logic [ecode_w-1:0] ecode_ade = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine = 6'h0d;

    localparam logic [8:0] crmd_reset = 9'h008; // direct address mode, plv0

    typedef enum logic [2:0] {
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_ertn,
        op_excp
    } csr_op_e;

    typedef struct packed {
        csr_op_e               op;
        logic [csr_num_w-1:0]  num;
        logic [xlen-1:0]       wdata;
        logic [xlen-1:0]       wmask;
        logic [xlen-1:0]       pc;
        logic [ecode_w-1:0]    ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [xlen-1:0]       badv;    // faulting address for ade/ale
    } csr_cmd_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] rdata;
        logic            redirect;
        logic [xlen-1:0] redirect_pc;
    } csr_resp_t;

    typedef struct packed {
        logic                  valid;
        csr_op_e               op;
        logic [csr_num_w-1:0]  num;
        logic [xlen-1:0]       wdata;   // already merged under mask
        logic [xlen-1:0]       pc;
        logic [ecode_w-1:0]    ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [xlen-1:0]       badv;
    } csr_commit_t;

    typedef struct packed {
        logic [2:0]      plv_ie;
        logic [xlen-1:0] era;
        logic [xlen-1:0] eentry;
        logic            int_pending;
    } csr_ctrl_state_t;

endpackage

//--- csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [csr_pkg::hw_irq_w-1:0]  irq,
    input  logic [csr_pkg::csr_num_w-1:0] rd_num,
    output logic [csr_pkg::xlen-1:0]      rd_data,
    input  csr_pkg::csr_commit_t          commit,
    output csr_pkg::csr_ctrl_state_t      state,
    output logic                          timer_irq
);
    import csr_pkg::*;

    logic [8:0]            crmd;
    logic [2:0]            prmd;
    logic [lie_w-1:0]      ecfg_lie;
    logic [1:0]            estat_is;
    logic [ecode_w-1:0]    estat_ecode;
    logic [esubcode_w-1:0] estat_esubcode;
    logic [xlen-1:0]       era;
    logic [xlen-1:0]       badv;
    logic [xlen-7:0]       eentry;          // bits 31:6
    logic [xlen-1:0]       save [4];
    logic [xlen-1:0]       tid;

    logic [xlen-1:0]       tcfg;
    logic [xlen-1:0]       tval;
    logic                  ti_pending;
    logic [xlen-1:0]       estat;
    logic [lie_w-1:0]      int_vec;
    logic                  csr_wr;
    logic                  tcfg_wr;
    logic                  ti_clear;

    assign csr_wr   = commit.valid && (commit.op == op_csrwr || commit.op == op_csrxchg);
    assign tcfg_wr  = csr_wr && (commit.num == csr_tcfg);
    assign ti_clear = csr_wr && (commit.num == csr_ticlr) && commit.wdata[0];

    csr_timer timer_i (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_wr    (tcfg_wr),
        .ti_clear   (ti_clear),
        .wdata      (commit.wdata),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_pending (ti_pending)
    );

    assign timer_irq = ti_pending;

    // live irq and timer bits, ipi slot and bit 10 read zero
    assign estat = {1'b0, estat_esubcode, estat_ecode, 3'b000, 1'b0, ti_pending, 1'b0,
                    irq, estat_is};

    assign int_vec = {1'b0, ti_pending, 1'b0, irq, estat_is} & ecfg_lie;

    always_comb
    begin
        state.plv_ie      = crmd[2:0];
        state.era         = era;
        state.eentry      = {eentry, 6'b000000};
        state.int_pending = |int_vec;   // ie applied by the trap controller
    end

    always_comb
    begin
        case (rd_num)
            csr_crmd:   rd_data = xlen'(crmd);
            csr_prmd:   rd_data = xlen'(prmd);
            csr_ecfg:   rd_data = xlen'(ecfg_lie);
            csr_estat:  rd_data = estat;
            csr_era:    rd_data = era;
            csr_badv:   rd_data = badv;
            csr_eentry: rd_data = {eentry, 6'b000000};
            csr_save0, csr_save1, csr_save2, csr_save3:
                rd_data = save[rd_num[1:0]];
            csr_tid:    rd_data = tid;
            csr_tcfg:   rd_data = tcfg;
            csr_tval:   rd_data = tval;
            default:    rd_data = '0;   // ticlr and unknown numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= crmd_reset;
            prmd           <= '0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry         <= '0;
            save           <= '{default: '0};
            tid            <= '0;
        end
        else if (commit.valid)
        begin
            case (commit.op)
                op_csrwr, op_csrxchg:
                begin
                    case (commit.num)
                        csr_crmd:   crmd     <= commit.wdata[8:0];
                        csr_prmd:   prmd     <= commit.wdata[2:0];
                        csr_ecfg:   ecfg_lie <= {commit.wdata[12:11], 1'b0, commit.wdata[9:0]};
                        csr_estat:  estat_is <= commit.wdata[1:0];  // only sw bits
                        csr_era:    era      <= commit.wdata;
                        csr_badv:   badv     <= commit.wdata;
                        csr_eentry: eentry   <= commit.wdata[xlen-1:6];
                        csr_save0, csr_save1, csr_save2, csr_save3:
                            save[commit.num[1:0]] <= commit.wdata;
                        csr_tid:    tid      <= commit.wdata;
                        default:    ;
                    endcase
                end
                op_excp:
                begin
                    prmd           <= crmd[2:0];
                    crmd[2:0]      <= 3'b000;   // plv0, interrupts off
                    era            <= commit.pc;
                    estat_ecode    <= commit.ecode;
                    estat_esubcode <= commit.esubcode;
                    if (commit.ecode == ecode_ade || commit.ecode == ecode_ale)
                        badv <= commit.badv;
                end
                op_ertn:
                    crmd[2:0] <= prmd;
                default: ;
            endcase
        end
    end

endmodule

//--- csr_timer.sv
`timescale 1ns/10ps

module csr_timer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tcfg_wr,
    input  logic                     ti_clear,
    input  logic [csr_pkg::xlen-1:0] wdata,
    output logic [csr_pkg::xlen-1:0] tcfg,
    output logic [csr_pkg::xlen-1:0] tval,
    output logic                     ti_pending
);
    import csr_pkg::*;

    logic            en;
    logic            periodic;
    logic            expire;
    logic [xlen-1:0] init_val;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[xlen-1:2], 2'b00};
    assign expire   = en && !tcfg_wr && (tval == xlen'(1)); // last tick before zero

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg       <= '0;
            tval       <= '0;
            ti_pending <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
            begin
                tcfg <= wdata;
                if (wdata[0])
                    tval <= {wdata[xlen-1:2], 2'b00};
            end
            else if (en)
            begin
                if (tval != '0)
                    tval <= tval - 1'b1;
                else if (periodic)
                    tval <= init_val;   // one-shot just sits at zero
            end

            if (ti_clear)
                ti_pending <= 1'b0;
            else if (expire)
                ti_pending <= 1'b1;
        end
    end

endmodule

//--- csr_trap_ctrl.sv
`timescale 1ns/10ps

module csr_trap_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  csr_pkg::csr_cmd_t             cmd,
    input  logic                          cmd_valid,
    input  logic                          stall,
    output logic [csr_pkg::csr_num_w-1:0] rd_num,
    input  logic [csr_pkg::xlen-1:0]      rd_data,
    input  csr_pkg::csr_ctrl_state_t      state,
    output csr_pkg::csr_commit_t          commit,
    output csr_pkg::csr_resp_t            resp
);
    import csr_pkg::*;

    logic                  accept;
    logic                  take_int;
    csr_op_e               op;
    logic [ecode_w-1:0]    ecode;
    logic [esubcode_w-1:0] esubcode;
    logic [xlen-1:0]       mask;
    logic [xlen-1:0]       merged;
    logic                  redirect;
    logic [xlen-1:0]       target;

    assign accept   = cmd_valid && !stall;
    assign take_int = state.int_pending && state.plv_ie[2];  // crmd.ie
    assign rd_num   = cmd.num;

    // interrupt replaces whatever command is accepted
    always_comb
    begin
        op       = cmd.op;
        ecode    = cmd.ecode;
        esubcode = cmd.esubcode;
        if (take_int)
        begin
            op       = op_excp;
            ecode    = ecode_int;
            esubcode = '0;
        end
    end

    assign mask   = (cmd.op == op_csrxchg) ? cmd.wmask : '1;
    assign merged = (rd_data & ~mask) | (cmd.wdata & mask);

    always_comb
    begin
        redirect = 1'b1;
        target   = cmd.pc + xlen'(4);
        case (op)
            op_csrrd:
            begin
                redirect = 1'b0;
                target   = '0;
            end
            op_ertn: target = state.era;
            op_excp: target = state.eentry;
            default: ;  // wr/xchg refetch next pc
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            resp         <= '0;
            commit.valid <= 1'b0;
        end
        else
        begin
            resp.valid    <= accept;   // one cycle only, even under stall
            resp.redirect <= accept && redirect;
            commit.valid  <= accept;
            if (accept)
            begin
                resp.rdata       <= rd_data;
                resp.redirect_pc <= target;
                commit.op        <= op;
                commit.num       <= cmd.num;
                commit.wdata     <= merged;
                commit.pc        <= cmd.pc;
                commit.ecode     <= ecode;
                commit.esubcode  <= esubcode;
                commit.badv      <= cmd.badv;
            end
        end
    end

endmodule

//--- csr_unit.sv
`timescale 1ns/10ps

module csr_unit (
    input  logic                         clk,
    input  logic                         rstn,
    input  csr_pkg::csr_cmd_t            cmd,
    input  logic                         cmd_valid,
    input  logic                         stall,
    input  logic [csr_pkg::hw_irq_w-1:0] irq,
    output csr_pkg::csr_resp_t           resp,
    output logic                         timer_irq
);
    import csr_pkg::*;

    logic [csr_num_w-1:0] rd_num;
    logic [xlen-1:0]      rd_data;
    csr_commit_t          commit;
    csr_ctrl_state_t      state;

    csr_trap_ctrl trap_ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .stall     (stall),
        .rd_num    (rd_num),
        .rd_data   (rd_data),
        .state     (state),
        .commit    (commit),
        .resp      (resp)
    );

    csr_regfile regfile_i (
        .clk       (clk),
        .rstn      (rstn),
        .irq       (irq),
        .rd_num    (rd_num),
        .rd_data   (rd_data),
        .commit    (commit),
        .state     (state),
        .timer_irq (timer_irq)
    );

endmodule

//--- csr_unit_assertions.sv
`timescale 1ns/10ps

module csr_unit_assertions (
    input logic               clk,
    input logic               rstn,
    input logic               cmd_valid,
    input logic               stall,
    input csr_pkg::csr_resp_t resp,
    input logic               timer_irq
);

    int fail_count = 0;

    redirect_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
        resp.redirect |-> resp.valid)
        else
        begin
            $error("redirect seen without a valid response");
            fail_count++;
        end

    // no new acceptance means the response drops next cycle
    valid_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        (resp.valid && !(cmd_valid && !stall)) |=> !resp.valid)
        else
        begin
            $error("response valid held longer than one cycle");
            fail_count++;
        end

    outputs_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown({resp, timer_irq}))
        else
        begin
            $error("unknown value on a csr_unit output");
            fail_count++;
        end

endmodule

bind csr_unit csr_unit_assertions assertions_i (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_valid (cmd_valid),
    .stall     (stall),
    .resp      (resp),
    .timer_irq (timer_irq)
);

//--- csr_unit_tb.sv
`timescale 1ns/10ps

module csr_unit_tb;
    import csr_pkg::*;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic [xlen-1:0] care;      // rdata bits that are compared
        logic            redirect;
        logic [xlen-1:0] redirect_pc;
    } resp_exp_t;

    localparam int total_cmds = 100;

    logic                clk;
    logic                rstn;
    csr_cmd_t            cmd;
    logic                cmd_valid;
    logic                stall;
    logic [hw_irq_w-1:0] irq;
    csr_resp_t           resp;
    logic                timer_irq;

    logic [xlen-1:0] shadow [0:(1 << csr_num_w)-1];
    resp_exp_t       exp_q [$];
    resp_exp_t       e_cur;
    logic [xlen-1:0] last_rdata;
    logic [xlen-1:0] pc_now = 32'h1c00_0000;
    integer          seed   = 32'h20ff_0e43;
    int              errors = 0;
    int              checks = 0;
    int              ntests = 0;

    csr_unit csr_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .stall     (stall),
        .irq       (irq),
        .resp      (resp),
        .timer_irq (timer_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected response of one command and the shadow update it causes
    function automatic resp_exp_t csr_model(input csr_cmd_t c, input logic [7:0] irq_now);
        resp_exp_t       r;
        logic [xlen-1:0] old;
        logic [xlen-1:0] mask;
        logic [xlen-1:0] merged;
        logic [12:0]     pend;
        csr_op_e         op;
        logic [5:0]      ecode;
        logic [8:0]      esub;
        old = shadow[c.num];
        if (c.num == csr_estat)
            old = old | {22'd0, irq_now, 2'b00};
        pend  = {3'b000, irq_now, shadow[csr_estat][1:0]} & shadow[csr_ecfg][12:0];
        op    = c.op;
        ecode = c.ecode;
        esub  = c.esubcode;
        if (pend != '0 && shadow[csr_crmd][2])
        begin
            op    = op_excp;   // interrupt taken at this command
            ecode = ecode_int;
            esub  = '0;
        end
        mask          = (c.op == op_csrxchg) ? c.wmask : 32'hffff_ffff;
        merged        = (old & ~mask) | (c.wdata & mask);
        r.rdata       = old;
        r.care        = 32'hffff_ffff;
        r.redirect    = (op != op_csrrd);
        r.redirect_pc = c.pc + 32'd4;
        case (op)
            op_csrwr, op_csrxchg:
            begin
                case (c.num)
                    csr_crmd:   shadow[c.num] = merged & 32'h0000_01ff;
                    csr_prmd:   shadow[c.num] = merged & 32'h0000_0007;
                    csr_ecfg:   shadow[c.num] = merged & 32'h0000_1bff;   // lie bit 10 reserved
                    csr_estat:  shadow[c.num] = (shadow[c.num] & ~32'h3) | (merged & 32'h3);
                    csr_eentry: shadow[c.num] = merged & 32'hffff_ffc0;
                    csr_tval, csr_ticlr: ;
                    default:    shadow[c.num] = merged;
                endcase
            end
            op_ertn:
            begin
                r.redirect_pc         = shadow[csr_era];
                shadow[csr_crmd][2:0] = shadow[csr_prmd][2:0];
            end
            op_excp:
            begin
                r.redirect_pc         = shadow[csr_eentry];
                shadow[csr_prmd]      = {29'd0, shadow[csr_crmd][2:0]};
                shadow[csr_crmd][2:0] = 3'b000;
                shadow[csr_era]       = c.pc;
                shadow[csr_estat]     = {1'b0, esub, ecode, 14'd0, shadow[csr_estat][1:0]};
                if (ecode == ecode_ade || ecode == ecode_ale)
                    shadow[csr_badv] = c.badv;
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            $display("error %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    function automatic csr_cmd_t make_cmd(input csr_op_e op, input logic [13:0] num,
                                          input logic [31:0] wdata, input logic [31:0] wmask);
        csr_cmd_t c;
        c       = '0;
        c.op    = op;
        c.num   = num;
        c.wdata = wdata;
        c.wmask = wmask;
        c.pc    = pc_now;
        pc_now  = pc_now + 32'd4;
        return c;
    endfunction

    // drive one command with an optional stall and wait for its response
    task automatic issue(input csr_cmd_t c, input logic [31:0] care, input int stall_cycles);
        resp_exp_t e;
        int        n;
        @(posedge clk);
        #1;
        cmd       = c;
        cmd_valid = 1'b1;
        if (stall_cycles > 0)
        begin
            stall = 1'b1;
            repeat (stall_cycles) @(posedge clk);
            #1;
            stall = 1'b0;
        end
        e      = csr_model(c, irq);
        e.care = care;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 4)
        begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("no response arrived for the command to csr %h", c.num);
            errors++;
            exp_q.delete();
        end
        else if (n != 1)
        begin
            $display("the response to csr %h came %0d cycles after acceptance, not one",
                     c.num, n);
            errors++;
        end
        #1;
    endtask

    task automatic read_csr(input logic [13:0] num);
        issue(make_cmd(op_csrrd, num, '0, '0), 32'hffff_ffff, 0);
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data);
        issue(make_cmd(op_csrwr, num, data, '0), 32'hffff_ffff, 0);
    endtask

    task automatic report_test(input string name, input int err_start);
        ntests++;
        $display("test %0d %s done, %0d errors", ntests, name, errors - err_start);
    endtask

    always @(negedge clk)
    begin
        if (rstn && resp.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("a response came with no command accepted");
                errors++;
            end
            else
            begin
                e_cur      = exp_q.pop_front();
                last_rdata = resp.rdata;
                check_val("resp.rdata", resp.rdata & e_cur.care, e_cur.rdata & e_cur.care);
                check_val("resp.redirect", resp.redirect, e_cur.redirect);
                if (e_cur.redirect)
                    check_val("resp.redirect_pc", resp.redirect_pc, e_cur.redirect_pc);
            end
        end
    end

    initial
    begin
        repeat (total_cmds * 40) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        logic [13:0] targets [6];
        logic [13:0] num;
        logic [31:0] data;
        csr_cmd_t    c;
        logic        fired;
        int          err0;
        rstn      = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        stall     = 1'b0;
        irq       = '0;
        targets   = '{csr_save0, csr_save1, csr_save2, csr_save3, csr_ecfg, csr_eentry};
        foreach (shadow[k])
            shadow[k] = '0;
        shadow[csr_crmd] = 32'h0000_0008;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        err0 = errors;
        check_val("resp.valid", resp.valid, 0);
        check_val("resp.redirect", resp.redirect, 0);
        check_val("timer_irq", timer_irq, 0);
        read_csr(csr_crmd);
        read_csr(csr_prmd);
        read_csr(csr_ecfg);
        read_csr(csr_era);
        read_csr(csr_save0);
        read_csr(csr_tcfg);
        report_test("reset values", err0);

        err0 = errors;
        for (int i = 0; i < 16; i++)
        begin
            num  = targets[{$random(seed)} % 6];
            data = $random(seed);
            if (i % 2 == 0)
                write_csr(num, data);
            else
                issue(make_cmd(op_csrxchg, num, data, $random(seed)), 32'hffff_ffff, 0);
            read_csr(num);
        end
        report_test("read write exchange", err0);

        err0 = errors;
        write_csr(csr_crmd, 32'h0000_000f);     // plv3, ie on
        c       = make_cmd(op_excp, csr_crmd, '0, '0);
        c.ecode = ecode_ale;
        c.badv  = $random(seed);
        issue(c, 32'hffff_ffff, 0);
        read_csr(csr_era);
        read_csr(csr_badv);
        read_csr(csr_estat);
        read_csr(csr_crmd);
        check_val("crmd.plv_ie", last_rdata[2:0], 3'b000);
        read_csr(csr_prmd);
        check_val("prmd", last_rdata, 32'h0000_0007);
        issue(make_cmd(op_ertn, csr_crmd, '0, '0), 32'hffff_ffff, 0);
        read_csr(csr_crmd);
        report_test("exception and ertn", err0);

        err0 = errors;
        write_csr(csr_ecfg, 32'h0000_0004);
        write_csr(csr_crmd, 32'h0000_000c);
        irq = 8'h01;
        c   = make_cmd(op_csrrd, csr_save0, '0, '0);
        issue(c, 32'hffff_ffff, 0);
        read_csr(csr_estat);
        read_csr(csr_era);
        check_val("era", last_rdata, c.pc);
        irq = 8'h00;
        report_test("hardware interrupt", err0);

        err0  = errors;
        fired = 1'b0;
        write_csr(csr_tcfg, 32'h0000_0011);     // init 16, one-shot
        for (int i = 0; i < 40 && !fired; i++)
        begin
            issue(make_cmd(op_csrrd, csr_estat, '0, '0), ~32'h0000_0800, 0);
            fired = last_rdata[11];
        end
        check_val("estat.ti", fired, 1);
        check_val("timer_irq", timer_irq, 1);
        write_csr(csr_ticlr, 32'h0000_0001);
        read_csr(csr_estat);
        check_val("timer_irq", timer_irq, 0);
        report_test("timer", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++)
            issue(make_cmd(op_csrrd, targets[i], '0, '0), 32'hffff_ffff, 1 + {$random(seed)} % 5);
        report_test("stall", err0);

        errors += csr_unit_i.assertions_i.fail_count;   // bound checker failures
        $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- vlog.f
csr_pkg.sv
csr_timer.sv
csr_regfile.sv
csr_trap_ctrl.sv
csr_unit.sv
csr_unit_assertions.sv
csr_unit_tb.sv
